/* Bender.yml */
package:
  name: rp_top

sources:
  - rp_pkg.sv
  - adc_frontend.sv
  - dac_backend.sv
  - hk_regs.sv
  - pwm_dac.sv
  - bus_sequencer.sv
  - rp_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rp_top.sv

/* adc_frontend.sv */
/* adc input stage
   registers the pins, converts to two's complement, optional loopback */
`timescale 1ns/1ps

module adc_frontend
  import rp_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  logic [ADC_W-1:0] adc_dat_a_i,           // offset binary, neg slope
  input  logic [ADC_W-1:0] adc_dat_b_i,
  input  logic             loop_en_i,
  input  sample_pair_t     loop_i,                // registered dac word
  output sample_pair_t     adc_o
);

  logic [ADC_W-1:0] pin_a_q;
  logic [ADC_W-1:0] pin_b_q;
  sample_pair_t     conv;

  // io registers
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pin_a_q <= '0;
      pin_b_q <= '0;
    end
    else
    begin
      pin_a_q <= adc_dat_a_i;
      pin_b_q <= adc_dat_b_i;
    end
  end

  assign conv.a = neg_slope(pin_a_q);             // keep msb, invert the rest
  assign conv.b = neg_slope(pin_b_q);

  assign adc_o = loop_en_i ? loop_i : conv;       // loopback replaces both channels

endmodule

/* all.f */
+incdir+.
rp_pkg.sv
adc_frontend.sv
dac_backend.sv
hk_regs.sv
pwm_dac.sv
bus_sequencer.sv
rp_top.sv
tb_rp_top.sv

/* bus_sequencer.sv */
/* bus sequencer
   latches one bus request, strobes the slave of the decoded region and
   returns its response registered, ack three cycles after the strobe */
`timescale 1ns/1ps

module bus_sequencer
  import rp_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    rst_n_i,
  input  bus_req_t                bus_req_i,      // from the master
  output bus_rsp_t                bus_rsp_o,
  output bus_req_t [REGION_N-1:0] slave_req_o,    // strobes on decoded lane only
  input  bus_rsp_t                hk_rsp_i,
  input  bus_rsp_t                pwm_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,                                         // waiting for wen/ren
    STROBE,                                       // slave strobe out
    RESPOND                                       // slave ack back, register it
  } seq_state_t;

  seq_state_t          state_q;
  bus_req_t            req_q;                     // latched request
  logic [REGION_W-1:0] region;
  bus_rsp_t            sel_rsp;                   // response of addressed region
  logic [BUS_DW-1:0]   rdata_q;
  logic                ack_q;
  logic                err_q;

  assign region = req_q.addr[REGION_LSB +: REGION_W];

  ////////////////////
  // state machine
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= IDLE;
    end
    else
    begin
      case (state_q)
        IDLE:    if (bus_req_i.wen || bus_req_i.ren) state_q <= STROBE;
        STROBE:  state_q <= RESPOND;
        RESPOND: state_q <= IDLE;                 // slaves always ack here
        default: state_q <= IDLE;
      endcase
    end
  end

  // request latch, only taken in IDLE
  always_ff @(posedge adc_clk)
  begin
    if (state_q == IDLE && (bus_req_i.wen || bus_req_i.ren))
      req_q <= bus_req_i;
  end

  ////////////////////
  // slave strobes
  always_comb
  begin
    for (int r = 0; r < REGION_N; r++)
    begin
      slave_req_o[r].addr  = req_q.addr;          // shared addr/data
      slave_req_o[r].wdata = req_q.wdata;
      slave_req_o[r].wen   = (state_q == STROBE) && req_q.wen && (region == REGION_W'(r));
      slave_req_o[r].ren   = (state_q == STROBE) && req_q.ren && (region == REGION_W'(r));
    end
  end

  ////////////////////
  // response mux
  always_comb
  begin
    case (region)
      REGION_W'(REGION_HK):  sel_rsp = hk_rsp_i;
      REGION_W'(REGION_PWM): sel_rsp = pwm_rsp_i;
      default:               sel_rsp = '{rdata: '0, ack: 1'b1, err: 1'b0};  // empty region
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= (state_q == RESPOND) && sel_rsp.ack;  // one-cycle pulse
      err_q <= (state_q == RESPOND) && sel_rsp.err;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (state_q == RESPOND)
      rdata_q <= sel_rsp.rdata;
  end

  assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule

/* dac_backend.sv */
/* dac output stage
   offset plus gated adc sample, saturated and registered, then
   driven to the pins in negative slope format */
`timescale 1ns/1ps

module dac_backend
  import rp_pkg::*;
(
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  sample_pair_t     adc_i,
  input  dac_cfg_t         cfg_i,
  output sample_pair_t     dac_o,                 // for digital loopback
  output logic [ADC_W-1:0] dac_dat_a_o,
  output logic [ADC_W-1:0] dac_dat_b_o
);

  sample_pair_t sum;                              // saturated, before the register
  sample_pair_t dac_q;

  // one bit wider add, clamp to +8191 / -8192 on overflow
  function automatic sample_t sat_sum(input sample_t smp, input logic en, input sample_t ofs);
    sample_t               gated;
    logic signed [ADC_W:0] wide;
    gated = en ? smp : sample_t'(0);              // no feed-through, offset only
    wide  = {ofs[ADC_W-1], ofs} + {gated[ADC_W-1], gated};
    if (wide[ADC_W] != wide[ADC_W-1])
      return {wide[ADC_W], {(ADC_W-1){~wide[ADC_W]}}};
    else
      return wide[ADC_W-1:0];
  endfunction

  assign sum.a = sat_sum(adc_i.a, cfg_i.feed_en[0], cfg_i.offset_a);
  assign sum.b = sat_sum(adc_i.b, cfg_i.feed_en[1], cfg_i.offset_b);

  ////////////////////
  // output register
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      dac_q <= '0;                                // pins idle at 0x1fff
    else
      dac_q <= sum;
  end

  assign dac_o = dac_q;

  // signed -> offset binary, negative slope
  assign dac_dat_a_o = neg_slope(dac_q.a);
  assign dac_dat_b_o = neg_slope(dac_q.b);

endmodule

/* hk_regs.sv */
/* housekeeping registers
   id word, leds, digital loopback, dac offsets and feed-through enables */
`timescale 1ns/1ps

module hk_regs
  import rp_pkg::*;
#(
  parameter logic [31:0] HK_ID = rp_pkg::HK_ID
) (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  input  bus_req_t   req_i,                       // decoded strobes from sequencer
  output bus_rsp_t   rsp_o,
  output dac_cfg_t   dac_cfg_o,
  output logic [7:0] led_o
);

  logic              loop_q;                      // digital loopback
  logic [7:0]        led_q;
  sample_t           ofs_a_q;
  sample_t           ofs_b_q;
  logic [1:0]        feed_q;                      // bit 0 ch a, bit 1 ch b
  logic [7:0]        ofs;                         // register offset
  logic [BUS_DW-1:0] rdata_q;
  logic              ack_q;

  assign ofs = req_i.addr[7:0];

  ////////////////////
  // write side
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q  <= 1'b0;
      led_q   <= '0;
      ofs_a_q <= '0;
      ofs_b_q <= '0;
      feed_q  <= '0;
    end
    else if (req_i.wen)
    begin
      case (ofs)
        OFS_LOOP:  loop_q  <= req_i.wdata[0];
        OFS_LED:   led_q   <= req_i.wdata[7:0];
        OFS_DAC_A: ofs_a_q <= req_i.wdata[ADC_W-1:0];
        OFS_DAC_B: ofs_b_q <= req_i.wdata[ADC_W-1:0];
        OFS_FEED:  feed_q  <= req_i.wdata[1:0];
        default:   ;                              // id and holes are read only
      endcase
    end
  end

  ////////////////////
  // read side, ack the cycle after any strobe
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req_i.wen || req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
    begin
      case (ofs)
        OFS_ID:    rdata_q <= HK_ID;
        OFS_LOOP:  rdata_q <= BUS_DW'(loop_q);
        OFS_LED:   rdata_q <= BUS_DW'(led_q);
        OFS_DAC_A: rdata_q <= BUS_DW'(ofs_a_q);   // sign extended
        OFS_DAC_B: rdata_q <= BUS_DW'(ofs_b_q);
        OFS_FEED:  rdata_q <= BUS_DW'(feed_q);
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o     = '{rdata: rdata_q, ack: ack_q, err: 1'b0};  // never errors
  assign dac_cfg_o = '{offset_a: ofs_a_q, offset_b: ofs_b_q, feed_en: feed_q, loop_en: loop_q};
  assign led_o     = led_q;

endmodule

/* pwm_dac.sv */
/* slow pwm dac
   free running period counter and per channel duty registers on the bus,
   each output high for duty counts of every period */
`timescale 1ns/1ps

module pwm_dac
  import rp_pkg::*;
#(
  parameter int PWM_W  = rp_pkg::PWM_W,           // counter and duty width
  parameter int PWM_CH = rp_pkg::PWM_CH
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  bus_req_t          req_i,
  output bus_rsp_t          rsp_o,
  output logic [PWM_CH-1:0] pwm_o
);

  logic [PWM_W-1:0]  cnt_q;                       // period counter, wraps
  logic [PWM_W-1:0]  duty_q [PWM_CH];
  logic [PWM_CH-1:0] pwm_q;
  logic [BUS_DW-1:0] rdata_q;
  logic              ack_q;

  ////////////////////
  // counter, duty registers, outputs
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q <= '0;
      pwm_q <= '0;
      ack_q <= 1'b0;
      for (int i = 0; i < PWM_CH; i++)
        duty_q[i] <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;
      ack_q <= req_i.wen || req_i.ren;            // ack the cycle after a strobe
      for (int i = 0; i < PWM_CH; i++)
      begin
        pwm_q[i] <= (cnt_q < duty_q[i]);          // high for duty out of 2**PWM_W
        if (req_i.wen && req_i.addr[7:0] == OFS_PWM_BASE + 8'(OFS_PWM_STEP * i))
          duty_q[i] <= req_i.wdata[PWM_W-1:0];
      end
    end
  end

  ////////////////////
  // read back
  always_ff @(posedge adc_clk)
  begin
    if (req_i.ren)
    begin
      rdata_q <= '0;                              // unknown offsets read zero
      for (int i = 0; i < PWM_CH; i++)
      begin
        if (req_i.addr[7:0] == OFS_PWM_BASE + 8'(OFS_PWM_STEP * i))
          rdata_q <= BUS_DW'(duty_q[i]);
      end
    end
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: 1'b0};
  assign pwm_o = pwm_q;

endmodule

/* rp_pkg.sv */
/* rp_pkg
   shared widths, bus region map, register offsets and the structs
   that carry bus traffic, samples and dac config between blocks */
package rp_pkg;

  ////////////////////
  // widths and region map
  localparam int ADC_W      = 14;                 // sample width, adc and dac
  localparam int BUS_AW     = 32;                 // bus address
  localparam int BUS_DW     = 32;                 // bus data
  localparam int REGION_N   = 8;                  // regions on the system bus
  localparam int REGION_LSB = 20;                 // region field is addr[22:20]
  localparam int REGION_W   = $clog2(REGION_N);
  localparam int REGION_HK  = 0;                  // housekeeping
  localparam int REGION_PWM = 4;                  // slow pwm dac

  ////////////////////
  // constants and register offsets
  localparam int PWM_W  = 8;                      // duty and period counter width
  localparam int PWM_CH = 4;
  localparam logic [BUS_DW-1:0] HK_ID = 32'h5250_0a01;  // read-only id word

  // housekeeping, low address byte
  localparam logic [7:0] OFS_ID    = 8'h00;
  localparam logic [7:0] OFS_LOOP  = 8'h04;       // bit 0
  localparam logic [7:0] OFS_LED   = 8'h08;       // 8 leds
  localparam logic [7:0] OFS_DAC_A = 8'h10;       // signed offset, ch a
  localparam logic [7:0] OFS_DAC_B = 8'h14;
  localparam logic [7:0] OFS_FEED  = 8'h18;       // bit 0 ch a, bit 1 ch b

  // pwm duty registers, one word per channel
  localparam logic [7:0] OFS_PWM_BASE = 8'h00;
  localparam int         OFS_PWM_STEP = 4;

  ////////////////////
  // types
  typedef logic signed [ADC_W-1:0] sample_t;

  typedef struct packed {
    sample_t a;                                   // channel a
    sample_t b;                                   // channel b
  } sample_pair_t;

  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              wen;                       // one-cycle strobes
    logic              ren;
  } bus_req_t;

  typedef struct packed {
    logic [BUS_DW-1:0] rdata;                     // valid with ack
    logic              ack;
    logic              err;
  } bus_rsp_t;

  typedef struct packed {
    sample_t    offset_a;
    sample_t    offset_b;
    logic [1:0] feed_en;                          // adc feed-through per channel
    logic       loop_en;                          // digital loopback
  } dac_cfg_t;

  // offset binary, negative slope <-> two's complement, same rule both ways
  function automatic logic [ADC_W-1:0] neg_slope(input logic [ADC_W-1:0] d);
    return {d[ADC_W-1], ~d[ADC_W-2:0]};
  endfunction

endpackage

/* rp_top.sv */
/* rp_top
   single clock analog path and bus control plane: bus sequencer,
   housekeeping, slow pwm dac, adc input stage and dac output stage */
`timescale 1ns/1ps

module rp_top
  import rp_pkg::*;
#(
  parameter logic [31:0] HK_ID  = rp_pkg::HK_ID,   // id word seen at OFS_ID
  parameter int          PWM_W  = rp_pkg::PWM_W,
  parameter int          PWM_CH = rp_pkg::PWM_CH
) (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  // adc pins, negative slope
  input  logic [ADC_W-1:0]  adc_dat_a_i,
  input  logic [ADC_W-1:0]  adc_dat_b_i,
  // system bus
  input  bus_req_t          bus_req_i,
  output bus_rsp_t          bus_rsp_o,
  // dac pins, negative slope
  output logic [ADC_W-1:0]  dac_dat_a_o,
  output logic [ADC_W-1:0]  dac_dat_b_o,
  output logic [PWM_CH-1:0] dac_pwm_o,            // slow pwm dac
  output logic [7:0]        led_o
);

  ////////////////////
  // local signals
  bus_req_t [REGION_N-1:0] slave_req;             // one lane per region
  bus_rsp_t                hk_rsp;
  bus_rsp_t                pwm_rsp;
  dac_cfg_t                dac_cfg;
  sample_pair_t            adc_smp;               // converted adc or loopback
  sample_pair_t            dac_smp;               // registered dac word

  ////////////////////
  // bus decode
  bus_sequencer u_seq (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .bus_req_i   (bus_req_i),
    .bus_rsp_o   (bus_rsp_o),
    .slave_req_o (slave_req),
    .hk_rsp_i    (hk_rsp),
    .pwm_rsp_i   (pwm_rsp)
  );

  hk_regs #(.HK_ID(HK_ID)) u_hk (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .req_i     (slave_req[REGION_HK]),            // region 0
    .rsp_o     (hk_rsp),
    .dac_cfg_o (dac_cfg),
    .led_o     (led_o)
  );

  pwm_dac #(.PWM_W(PWM_W), .PWM_CH(PWM_CH)) u_pwm (
    .adc_clk (adc_clk),
    .rst_n_i (rst_n_i),
    .req_i   (slave_req[REGION_PWM]),             // region 4
    .rsp_o   (pwm_rsp),
    .pwm_o   (dac_pwm_o)
  );

  ////////////////////
  // analog path
  adc_frontend u_adc (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (dac_cfg.loop_en),
    .loop_i      (dac_smp),                       // dac word fed back
    .adc_o       (adc_smp)
  );

  dac_backend u_dac (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_i       (adc_smp),
    .cfg_i       (dac_cfg),
    .dac_o       (dac_smp),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

/* tb_bus_tasks.svh */
/* bus and adc helpers for the rp_top testbench
   bus write/read with ack timeout, adc pin drive, pin format conversion */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

////////////////////
// conversions

// region field at addr[22:20], register offset in the low byte
function automatic logic [31:0] region_addr(input int region, input logic [7:0] ofs);
  return (32'(region) << 20) | 32'(ofs);
endfunction

// signed value -> pin word, msb kept, rest inverted
function automatic logic [13:0] to_pins(input int s);
  logic [13:0] v;
  v = s[13:0];
  return {v[13], ~v[12:0]};
endfunction

function automatic int from_pins(input logic [13:0] p);
  logic signed [13:0] s;
  s = {p[13], ~p[12:0]};
  return s;                                       // sign extended
endfunction

// offset plus gated sample, clamped to the 14 bit range
function automatic int dac_expect(input int smp, input logic en, input int ofs);
  int sum;
  sum = ofs + (en ? smp : 0);
  if (sum > 8191)
    sum = 8191;
  else if (sum < -8192)
    sum = -8192;
  return sum;
endfunction

////////////////////
// bus and adc drive
task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata, input logic wr,
                          output logic [31:0] rdata, output logic err, output int lat);
  int   n;
  logic err_seen;
  n        = 0;
  err_seen = 1'b0;
  @(posedge adc_clk);
  bus_req <= '{addr: addr, wdata: wdata, wen: wr, ren: !wr};   // strobe cycle
  do
  begin
    @(posedge adc_clk);
    bus_req.wen <= 1'b0;                          // one cycle only
    bus_req.ren <= 1'b0;
    n++;
    @(negedge adc_clk);
    err_seen |= bus_rsp.err;
  end while (!bus_rsp.ack && n < ACK_TIMEOUT);
  if (!bus_rsp.ack)
  begin
    $display("no bus ack within %0d cycles for address 0x%08h", ACK_TIMEOUT, addr);
    abort_run();
  end
  rdata = bus_rsp.rdata;
  err   = err_seen;
  lat   = n;
endtask

task automatic bus_write(input string test, input logic [31:0] addr, input logic [31:0] data);
  logic [31:0] rd;
  logic        err;
  int          lat;
  bus_access(addr, data, 1'b1, rd, err, lat);
  check_value({test, " ack latency"}, 32'd3, 32'(lat));
  check_value({test, " err"}, 32'd0, 32'(err));
endtask

task automatic bus_read(input string test, input logic [31:0] addr, output logic [31:0] data);
  logic err;
  int   lat;
  bus_access(addr, 32'h0, 1'b0, data, err, lat);
  check_value({test, " ack latency"}, 32'd3, 32'(lat));
  check_value({test, " err"}, 32'd0, 32'(err));
endtask

task automatic drive_adc(input logic [13:0] a, input logic [13:0] b);
  @(posedge adc_clk);
  adc_dat_a <= a;
  adc_dat_b <= b;
endtask

`endif

/* tb_rp_top.sv */
/* rp_top testbench
   directed tests for bus access, empty regions, dac sum and clamp,
   offset only output, digital loopback and pwm duty */
`timescale 1ns/1ps

module tb_rp_top
  import rp_pkg::*;
();

  localparam logic [31:0] EXP_ID      = 32'h5250_0a01;  // id word the dut must return
  localparam int          ACK_TIMEOUT = 20;             // cycles

  logic        adc_clk;
  logic        rst_n_i;
  logic [13:0] adc_dat_a;
  logic [13:0] adc_dat_b;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic [13:0] dac_a;
  logic [13:0] dac_b;
  logic [3:0]  pwm;
  logic [7:0]  led;
  integer      seed;

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;                // 100 MHz
  end

  rp_top u_dut (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .dac_dat_a_o (dac_a),
    .dac_dat_b_o (dac_b),
    .dac_pwm_o   (pwm),
    .led_o       (led)
  );

  ////////////////////
  // failure handling
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string test, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("Fail %s: expected 0x%0h, actual 0x%0h", test, exp, act);
      abort_run();
    end
  endtask

  `include "tb_bus_tasks.svh"

  // pins change, 2 cycles later the dac pins show the clamped sum
  task automatic check_dac(input string test, input int smp_a, input int smp_b,
                           input logic [1:0] feed, input int ofs_a, input int ofs_b);
    drive_adc(to_pins(smp_a), to_pins(smp_b));
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    check_value({test, " ch a"}, 32'(to_pins(dac_expect(smp_a, feed[0], ofs_a))), 32'(dac_a));
    check_value({test, " ch b"}, 32'(to_pins(dac_expect(smp_b, feed[1], ofs_b))), 32'(dac_b));
  endtask

  task automatic write_offsets(input int ofs_a, input int ofs_b);
    bus_write("offset a", region_addr(0, 8'h10), 32'(ofs_a));
    bus_write("offset b", region_addr(0, 8'h14), 32'(ofs_b));
  endtask

  ////////////////////
  // tests
  task automatic register_access();
    logic [31:0] rd;
    logic [7:0]  led_val;
    led_val = 8'($random(seed));
    bus_read("id read", region_addr(0, 8'h00), rd);
    check_value("id read", EXP_ID, rd);
    bus_write("led write", region_addr(0, 8'h08), 32'(led_val));
    check_value("led pins", 32'(led_val), 32'(led));
    bus_read("led read", region_addr(0, 8'h08), rd);
    check_value("led read", 32'(led_val), rd);
  endtask

  task automatic empty_regions();
    int          regions[6] = '{1, 2, 3, 5, 6, 7};
    logic [31:0] rd;
    logic [31:0] led_before;
    bus_read("led before", region_addr(0, 8'h08), led_before);
    foreach (regions[i])
    begin
      bus_read("empty read", region_addr(regions[i], 8'h08), rd);
      check_value($sformatf("empty region %0d read", regions[i]), 32'h0, rd);
      bus_write("empty write", region_addr(regions[i], 8'h08), 32'hffff_ffff);
      bus_write("empty write", region_addr(regions[i], 8'h00), 32'hffff_ffff);
    end
    bus_read("led after", region_addr(0, 8'h08), rd);
    check_value("led after empty writes", led_before, rd);
    bus_read("duty after", region_addr(4, 8'h00), rd);
    check_value("pwm duty after empty writes", 32'h0, rd);  // still reset value
  endtask

  task automatic dac_sum_clamp();
    int          ofs_a;
    int          ofs_b;
    logic [31:0] rd;
    bus_write("feed on", region_addr(0, 8'h18), 32'h3);
    repeat (8)
    begin
      ofs_a = $random(seed) % 8192;
      ofs_b = $random(seed) % 8192;
      write_offsets(ofs_a, ofs_b);
      check_dac("sum", from_pins(14'($random(seed))), from_pins(14'($random(seed))),
                2'b11, ofs_a, ofs_b);
    end
    bus_read("offset a read", region_addr(0, 8'h10), rd);
    check_value("offset a read", 32'(ofs_a), rd);           // sign extended
    // forced overflow both ways
    write_offsets(8000, -8000);
    bus_read("offset b read", region_addr(0, 8'h14), rd);
    check_value("offset b read", 32'(-8000), rd);           // negative, upper bits set
    check_dac("clamp pos/neg", 4000, -4000, 2'b11, 8000, -8000);
    write_offsets(-8000, 8000);
    check_dac("clamp neg/pos", -4000, 4000, 2'b11, -8000, 8000);
  endtask

  task automatic dac_offset_only();
    int ofs_a;
    int ofs_b;
    bus_write("feed off", region_addr(0, 8'h18), 32'h0);
    repeat (4)
    begin
      ofs_a = $random(seed) % 8192;
      ofs_b = $random(seed) % 8192;
      write_offsets(ofs_a, ofs_b);
      check_dac("offset only", from_pins(14'($random(seed))), from_pins(14'($random(seed))),
                2'b00, ofs_a, ofs_b);
    end
  endtask

  task automatic digital_loopback();
    int n;
    write_offsets(1000, 0);
    bus_write("feed on", region_addr(0, 8'h18), 32'h3);
    bus_write("loop on", region_addr(0, 8'h04), 32'h1);
    n = 0;
    do
    begin
      @(posedge adc_clk);
      adc_dat_a <= 14'($random(seed));            // ignored while looped
      n++;
      @(negedge adc_clk);
    end while (dac_a !== to_pins(8191) && n < 100);
    if (dac_a !== to_pins(8191))
    begin
      $display("dac channel a never reached full scale in loopback");
      abort_run();
    end
    repeat (16)
    begin
      @(posedge adc_clk);
      adc_dat_a <= 14'($random(seed));
      @(negedge adc_clk);
      check_value("loopback hold", 32'(to_pins(8191)), 32'(dac_a));
    end
    bus_write("loop off", region_addr(0, 8'h04), 32'h0);
  endtask

  task automatic pwm_duty();
    logic [7:0]  duty[4];
    int          high[4];
    logic [31:0] rd;
    for (int i = 0; i < 4; i++)
    begin
      duty[i] = 8'($random(seed));
      high[i] = 0;
      bus_write("duty write", region_addr(4, 8'(4 * i)), 32'(duty[i]));
    end
    for (int i = 0; i < 4; i++)
    begin
      bus_read("duty read", region_addr(4, 8'(4 * i)), rd);
      check_value($sformatf("duty read ch%0d", i), 32'(duty[i]), rd);
    end
    repeat (256)                                  // one full period
    begin
      @(negedge adc_clk);
      for (int i = 0; i < 4; i++)
        if (pwm[i])
          high[i]++;
    end
    for (int i = 0; i < 4; i++)
      check_value($sformatf("pwm high cycles ch%0d", i), 32'(duty[i]), 32'(high[i]));
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    seed      = 5;
    rst_n_i   = 1'b0;
    bus_req   = '0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    repeat (5) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    @(negedge adc_clk);
    check_value("reset dac a", 32'h1fff, 32'(dac_a));       // zero word, pin format
    check_value("reset dac b", 32'h1fff, 32'(dac_b));
    check_value("reset leds", 32'h0, 32'(led));
    check_value("reset pwm", 32'h0, 32'(pwm));
    register_access();
    empty_regions();
    dac_sum_clamp();
    dac_offset_only();
    digital_loopback();
    pwm_duty();
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
